/* Makefile */
VERILATOR ?= verilator
TOP       ?= mmuTb
FILELIST  ?= mmuWalk.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

/* bench/mmuTb.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmuTb
  import mmuPkg::*;
();

  localparam int numDirected   = 8 + 22 + 256;
  localparam int numRandom     = 200;
  localparam int cyclesPerWalk = 64;
  localparam physAddr_t l1AbortAddr = 32'h0000_4018;  // Faulting first-level entry
  localparam physAddr_t l2AbortAddr = 32'h0001_0010;

  logic        clk = 1'b0;
  logic        reset;
  logic        cpuRequest;
  logic        cpuWrite;
  virtAddr_t   virtAddr;
  logic        supMode;
  logic        wordAccess;
  logic        cpuReady;
  physAddr_t   hAddr;
  logic        hRequest;
  logic        hWrite;
  logic        hReady;
  descriptor_t hRData;
  logic [31:0] control;
  tableBase_t  tableBase;
  logic [31:0] domainAccess;
  logic        extAbort;
  logic        dataAbort;
  logic        cp15WriteEn;
  cp15Reg_t    cp15Addr;
  logic [31:0] cp15WriteData;

  descriptor_t mem [physAddr_t];  // Sparse page-table memory
  int          memVersion = 0;
  integer      seed = 32'h226e1284;

  // Expected outcome of the request in flight
  logic       expFault;
  logic       expWrite;
  physAddr_t  expAddr;
  faultCode_t expCode;
  domain_t    expDom;
  virtAddr_t  expVa;
  logic       active;
  logic       finished;
  int         cp15Step;
  int         i;
  int         k;
  int         dac;
  int         ap;
  int         sr;
  int         m;
  int         idx;
  logic [31:0] r;
  logic [31:0] dacr;
  virtAddr_t  va;
  virtAddr_t  vaBase [14] = '{32'h0010_0000, 32'h0020_0000, 32'h0020_1000, 32'h0020_2000,
                              32'h0020_3000, 32'h0020_4000, 32'h0030_0000, 32'h0030_4000,
                              32'h0030_0400, 32'h0030_0800, 32'h0030_0C00, 32'h0040_0000,
                              32'h0050_0000, 32'h0060_0000};

  mmuTop i_mmuTop (
    .clk           (clk),
    .reset         (reset),
    .cpuRequest    (cpuRequest),
    .cpuWrite      (cpuWrite),
    .virtAddr      (virtAddr),
    .supMode       (supMode),
    .wordAccess    (wordAccess),
    .cpuReady      (cpuReady),
    .hAddr         (hAddr),
    .hRequest      (hRequest),
    .hWrite        (hWrite),
    .hReady        (hReady),
    .hRData        (hRData),
    .control       (control),
    .tableBase     (tableBase),
    .domainAccess  (domainAccess),
    .extAbort      (extAbort),
    .dataAbort     (dataAbort),
    .cp15WriteEn   (cp15WriteEn),
    .cp15Addr      (cp15Addr),
    .cp15WriteData (cp15WriteData)
  );

  always #2 clk = ~clk;

  function automatic descriptor_t readMem(input physAddr_t a);
    if (mem.exists(a)) return mem[a];
    return ~{a[15:0], a[31:16]};  // Unmapped words
  endfunction

  always @(hAddr or memVersion) hRData = readMem(hAddr);
  assign extAbort = (hAddr == l1AbortAddr) || (hAddr == l2AbortAddr);

  always @(posedge clk) begin
    hReady <= ($random(seed) % 4) != 0;  // Roughly one wait cycle in four
  end

  task automatic writeMem(input physAddr_t a, input descriptor_t d);
    mem[a] = d;
    memVersion++;
  endtask

  function automatic descriptor_t sectionDesc(input logic [11:0] base, input accessPerm_t p,
                                              input domain_t dom);
    return {base, 8'h00, p, 1'b0, dom, 3'b000, 2'b10};
  endfunction

  function automatic descriptor_t tableDesc(input physAddr_t a, input domain_t dom,
                                            input logic [1:0] kind);
    return {a[31:10], 1'b0, dom, 3'b000, kind};
  endfunction

  function automatic descriptor_t pageDesc(input physAddr_t base, input logic [7:0] aps,
                                           input logic [1:0] kind);
    return base | {20'h0, aps, 2'b00, kind};
  endfunction

  function automatic accessPerm_t apPair(input descriptor_t d, input logic [1:0] sel);
    case (sel)
      2'd0: return d[5:4];
      2'd1: return d[7:6];
      2'd2: return d[9:8];
      default: return d[11:10];
    endcase
  endfunction

  function automatic logic apDenied(input accessPerm_t p, input logic wr, input logic sup);
    case (p)
      2'b11: return 1'b0;
      2'b10: return !sup && wr;
      2'b01: return !sup;
      default: begin
        if (control[`MMU_CTRL_SBIT] && !control[`MMU_CTRL_RBIT]) return !(sup && !wr);
        if (!control[`MMU_CTRL_SBIT] && control[`MMU_CTRL_RBIT]) return wr;
        return 1'b1;
      end
    endcase
  endfunction

  // Expected walk result with a return of 1 for an abort
  function automatic logic refWalk(input virtAddr_t a, input logic wr, input logic sup,
                                   input logic word, output physAddr_t pa,
                                   output faultCode_t code, output domain_t dom);
    descriptor_t d1;
    descriptor_t d2;
    physAddr_t   a1;
    physAddr_t   a2;
    logic [1:0]  entry;
    accessPerm_t p;
    logic        section;
    pa   = a;
    code = alignFault;
    dom  = '0;
    if (!control[`MMU_CTRL_ENABLE]) return 1'b0;
    if (word && (a[1:0] != 2'b00)) return 1'b1;
    a1 = {tableBase, a[31:20], 2'b00};
    d1 = readMem(a1);
    code = firstExtFault;
    if (a1 == l1AbortAddr) return 1'b1;
    code = sectionTransFault;
    if (d1[1:0] == 2'b00) return 1'b1;
    dom = d1[8:5];
    section = (d1[1:0] == 2'b10);
    if (section) begin
      pa = {d1[31:20], a[19:0]};
      p  = d1[11:10];
    end else begin
      if (d1[1]) a2 = {d1[31:12], a[19:10], 2'b00};  // Fine table
      else a2 = {d1[31:10], a[19:12], 2'b00};
      d2 = readMem(a2);
      code = secondExtFault;
      if (a2 == l2AbortAddr) return 1'b1;
      code = pageTransFault;
      if ((d2[1:0] == 2'b00) || (!d1[1] && (d2[1:0] == 2'b11))) return 1'b1;
      case (d2[1:0])
        2'b01: begin
          pa = {d2[31:16], a[15:0]};
          p  = apPair(d2, a[15:14]);
        end
        2'b10: begin
          pa = {d2[31:12], a[11:0]};
          p  = apPair(d2, a[11:10]);
        end
        default: begin
          pa = {d2[31:10], a[9:0]};
          p  = d2[5:4];
        end
      endcase
    end
    entry = domainAccess[2 * dom +: 2];
    code = section ? sectionDomainFault : pageDomainFault;
    if ((entry == 2'b00) || (entry == 2'b10)) return 1'b1;
    code = section ? sectionPermFault : pagePermFault;
    if ((entry == 2'b01) && apDenied(p, wr, sup)) return 1'b1;
    return 1'b0;
  endfunction

  task automatic failRun(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1);
  endtask

  task automatic checkAddr(input string name, input physAddr_t got, input physAddr_t exp);
    if (got !== exp) failRun($sformatf("error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp) failRun($sformatf("error: %s got %h expected %h", name, got, exp));
  endtask

  task automatic checkFault(input faultCode_t got, input faultCode_t exp);
    if (got !== exp) failRun($sformatf("error: FSR fault code got %h expected %h", got, exp));
  endtask

  task automatic checkCp15(input cp15Reg_t gotReg, input logic [31:0] gotData,
                           input cp15Reg_t expReg, input logic [31:0] expData);
    if (gotReg !== expReg)
      failRun($sformatf("error: cp15Addr got %h expected %h", gotReg, expReg));
    if (gotData !== expData)
      failRun($sformatf("error: cp15WriteData got %h expected %h", gotData, expData));
  endtask

  // Compare process sampling mid-cycle
  always @(negedge clk) begin
    if (!reset) begin
      if (!control[`MMU_CTRL_ENABLE]) begin
        checkAddr("hAddr", hAddr, virtAddr);
        checkBit("hRequest", hRequest, cpuRequest);
        checkBit("hWrite", hWrite, cpuWrite);
        checkBit("cpuReady", cpuReady, hReady);
      end
      if (cp15Step == 2) begin
        checkBit("cp15WriteEn", cp15WriteEn, 1'b1);
        checkCp15(cp15Addr, cp15WriteData, cp15Reg_t'(`MMU_CP15_FAR), expVa);
        cp15Step = 0;
      end else if (cp15Step == 1) begin
        checkBit("cp15WriteEn", cp15WriteEn, 1'b1);
        checkFault(faultCode_t'(cp15WriteData[3:0]), expCode);
        checkCp15(cp15Addr, cp15WriteData, cp15Reg_t'(`MMU_CP15_FSR),
                  {24'h0, expDom, expCode});
        cp15Step = 2;
      end else begin
        checkBit("cp15WriteEn", cp15WriteEn, 1'b0);
      end
      if (active && !finished) begin
        if (expFault && (expCode == alignFault) && hRequest)
          failRun("bus request issued for a misaligned word access");
        if (cpuReady && cpuRequest) begin
          if (expFault) failRun("request completed where an abort was expected");
          checkAddr("hAddr", hAddr, expAddr);
          checkBit("hRequest", hRequest, 1'b1);
          checkBit("hWrite", hWrite, expWrite);
          finished = 1'b1;
        end else if (dataAbort) begin
          if (!expFault) failRun("data abort on a request that should translate");
          // Descriptor faults abort in the completing fetch cycle
          checkBit("hRequest", hRequest,
                   expCode inside {sectionTransFault, pageTransFault,
                                   firstExtFault, secondExtFault});
          cp15Step = 1;
          finished = 1'b1;
        end
      end else if (dataAbort) begin
        failRun("data abort without a pending request");
      end
    end
  end

  task automatic setConfig(input logic [31:0] ctrl, input logic [31:0] dac);
    @(posedge clk);
    control      <= ctrl;
    domainAccess <= dac;
  endtask

  task automatic doRequest(input virtAddr_t a, input logic wr, input logic sup,
                           input logic word);
    @(posedge clk);
    expFault   = refWalk(a, wr, sup, word, expAddr, expCode, expDom);
    expVa      = a;
    expWrite   = wr;
    cpuRequest <= 1'b1;
    cpuWrite   <= wr;
    virtAddr   <= a;
    supMode    <= sup;
    wordAccess <= word;
    finished   = 1'b0;
    active     = 1'b1;
    wait (finished);
    @(posedge clk);
    cpuRequest <= 1'b0;
    active     = 1'b0;
    wait (cp15Step == 0);
  endtask

  task automatic buildTables();
    writeMem(32'h4004, sectionDesc(12'h801, 2'b11, 4'd0));
    writeMem(32'h4008, tableDesc(32'h0001_0000, 4'd1, 2'b01));  // Coarse
    writeMem(32'h400C, tableDesc(32'h0002_0000, 4'd2, 2'b11));  // Fine
    writeMem(32'h4010, 32'h0);
    writeMem(32'h4014, sectionDesc(12'h805, 2'b11, 4'd3));
    writeMem(32'h4018, sectionDesc(12'h806, 2'b11, 4'd0));
    writeMem(32'h10000, pageDesc(32'h9000_0000, 8'b11_10_01_11, 2'b10));
    writeMem(32'h10004, pageDesc(32'h9100_0000, 8'hFF, 2'b01));
    writeMem(32'h10008, pageDesc(32'h9200_0000, 8'h03, 2'b11));  // Tiny in coarse
    writeMem(32'h1000C, 32'h0);
    writeMem(32'h10010, pageDesc(32'h9300_0000, 8'hFF, 2'b10));
    for (k = 0; k < 4; k++) begin
      writeMem(32'h20000 + k * 64, pageDesc(32'hA000_0000, 8'b11_01_10_11, 2'b01));
    end
    writeMem(32'h20004, pageDesc(32'hA100_0000, 8'hFF, 2'b10));
    writeMem(32'h20008, pageDesc(32'hA200_0000, 8'h03, 2'b11));
    writeMem(32'h2000C, 32'h0);
  endtask

  // Watchdog
  initial begin
    #((numDirected + numRandom) * cyclesPerWalk * 4 + 1000);
    failRun("timeout: the walker stopped answering requests");
  end

  initial begin
    reset        = 1'b1;
    cpuRequest   = 1'b0;
    cpuWrite     = 1'b0;
    virtAddr     = '0;
    supMode      = 1'b0;
    wordAccess   = 1'b0;
    control      = 32'h0;
    tableBase    = 18'h00001;  // Tables at 0x4000
    domainAccess = 32'h5555_5555;
    hReady       = 1'b0;
    active       = 1'b0;
    finished     = 1'b0;
    cp15Step     = 0;
    buildTables();
    repeat (10) @(posedge clk);
    reset <= 1'b0;

    for (i = 0; i < 8; i++) doRequest($random(seed) & 32'h7FFF_FFF0, i[0], i[1], 1'b1);

    setConfig(32'h1, 32'h5555_5555);
    doRequest(32'h0012_3456, 1'b0, 1'b0, 1'b0);
    doRequest(32'h0012_3458, 1'b1, 1'b1, 1'b1);
    doRequest(32'h0020_0ABC, 1'b0, 1'b0, 1'b1);
    doRequest(32'h0020_1234, 1'b1, 1'b0, 1'b1);
    doRequest(32'h0020_2000, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0020_3000, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0020_4000, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0030_0104, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0030_0408, 1'b1, 1'b0, 1'b1);
    doRequest(32'h0030_0810, 1'b0, 1'b0, 1'b1);
    doRequest(32'h0030_0C00, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0040_0000, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0060_0000, 1'b0, 1'b1, 1'b1);
    doRequest(32'h0012_3457, 1'b0, 1'b1, 1'b1);
    for (k = 0; k < 4; k++) begin
      doRequest(32'h0020_0000 + k * 32'h400, 1'b1, 1'b0, 1'b1);  // Small subpages
      doRequest(32'h0030_0000 + k * 32'h4000, 1'b1, 1'b0, 1'b1);  // Large subpages
    end

    // Domain, AP and S/R sweep on the domain 3 section
    for (dac = 0; dac < 4; dac++) begin
      for (ap = 0; ap < 4; ap++) begin
        writeMem(32'h4014, sectionDesc(12'h805, ap[1:0], 4'd3));
        for (sr = 0; sr < 4; sr++) begin
          setConfig({22'h0, sr[0], 1'b0, sr[1], 6'h0, 1'b1}, {24'h555555, dac[1:0], 6'h15});
          for (m = 0; m < 4; m++) doRequest(32'h0050_0000 + m * 16, m[0], m[1], 1'b1);
        end
      end
    end

    for (i = 0; i < numRandom; i++) begin
      r = $random(seed);
      dacr = $random(seed);
      if (!r[5]) dacr = dacr | 32'h5555_5555;
      setConfig({22'h0, r[8], 1'b0, r[9], 6'h0, r[3:0] != 4'h0}, dacr);
      idx = (r >> 16) % 14;
      va = vaBase[idx] | ($random(seed) & 32'h3FF);
      doRequest(va, r[10], r[11], r[12]);
    end

    @(posedge clk);
    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* hdl/descriptorPath.sv */
`timescale 1ns/1ps
`default_nettype none

module descriptorPath
  import mmuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  walkState_t  state,
  input  logic        descCapture,
  input  descriptor_t hRData,
  input  virtAddr_t   virtAddr,
  input  tableBase_t  tableBase,
  output descriptor_t desc,
  output domain_t     domain,
  output physAddr_t   walkAddr
);

  // Holds the first-level word until the second-level one replaces it
  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      desc   <= '0;
      domain <= '0;
    end else if (descCapture) begin
      desc <= hRData;
      if (state == firstFetch) domain <= hRData[8:5];
    end
  end

  always_comb begin
    case (state)
      coarseFetch:  walkAddr = {desc[31:10], virtAddr[19:12], 2'b00};
      fineFetch:    walkAddr = {desc[31:12], virtAddr[19:10], 2'b00};
      sectionTrans: walkAddr = {desc[31:20], virtAddr[19:0]};
      largeTrans:   walkAddr = {desc[31:16], virtAddr[15:0]};
      smallTrans:   walkAddr = {desc[31:12], virtAddr[11:0]};
      tinyTrans:    walkAddr = {desc[31:10], virtAddr[9:0]};
      default:      walkAddr = {tableBase, virtAddr[31:20], 2'b00};  // First-level entry
    endcase
  end

  // Descriptor fetches are always whole words
  assert property (@(posedge clk) disable iff (reset)
    (state inside {firstFetch, coarseFetch, fineFetch}) |-> (walkAddr[1:0] == 2'b00))
    else $error("descriptorPath: unaligned descriptor fetch address %h", walkAddr);

endmodule

`default_nettype wire

/* hdl/faultReporter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module faultReporter
  import mmuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        dataAbort,
  input  faultCode_t  faultCode,
  input  domain_t     domain,
  input  virtAddr_t   virtAddr,
  output logic        cp15WriteEn,
  output cp15Reg_t    cp15Addr,
  output logic [31:0] cp15WriteData,
  output logic        reportBusy
);

  logic                       fsrPending;
  logic                       farPending;
  logic [`MMU_ADDR_WIDTH-1:0] fsrData;
  virtAddr_t                  farData;
  domain_t                    domainField;

  // No first-level descriptor has been read yet for these, so the domain reads as zero
  assign domainField =
    (faultCode inside {alignFault, sectionTransFault, firstExtFault}) ? '0 : domain;

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      fsrPending <= 1'b0;
      farPending <= 1'b0;
    end else begin
      fsrPending <= dataAbort;
      farPending <= fsrPending;  // FAR always follows the FSR
    end
  end

  always_ff @(posedge clk) begin
    if (dataAbort) begin
      fsrData <= {{(`MMU_ADDR_WIDTH - 8){1'b0}}, domainField, faultCode};
      farData <= virtAddr;
    end
  end

  assign reportBusy    = fsrPending || farPending;
  assign cp15WriteEn   = reportBusy;
  assign cp15Addr      = fsrPending ? cp15Reg_t'(`MMU_CP15_FSR) : cp15Reg_t'(`MMU_CP15_FAR);
  assign cp15WriteData = fsrPending ? fsrData : farData;

  // The walker holds off new walks until both writes are out
  assert property (@(posedge clk) disable iff (reset) dataAbort |-> !reportBusy)
    else $error("faultReporter: data abort while CP15 writes are pending");

endmodule

`default_nettype wire

/* hdl/mmuPkg.sv */
`default_nettype none

`include "mmu_config.svh"

package mmuPkg;

  typedef logic [`MMU_ADDR_WIDTH-1:0]  virtAddr_t;
  typedef logic [`MMU_ADDR_WIDTH-1:0]  physAddr_t;
  typedef logic [`MMU_ADDR_WIDTH-1:0]  descriptor_t;  // Page-table word
  typedef logic [3:0]                  domain_t;
  typedef logic [1:0]                  accessPerm_t;
  typedef logic [`MMU_TBASE_WIDTH-1:0] tableBase_t;
  typedef logic [3:0]                  cp15Reg_t;

  // FSR status encodings
  typedef enum logic [3:0] {
    alignFault         = 4'b0001,
    sectionTransFault  = 4'b0101,
    pageTransFault     = 4'b0111,
    sectionDomainFault = 4'b1001,
    pageDomainFault    = 4'b1011,
    sectionPermFault   = 4'b1101,
    pagePermFault      = 4'b1111,
    firstExtFault      = 4'b1100,
    secondExtFault     = 4'b1110
  } faultCode_t;

  typedef enum logic [2:0] {
    ready,
    firstFetch,
    coarseFetch,   // Second-level fetch from a coarse table
    fineFetch,     // Second-level fetch from a fine table
    sectionTrans,
    largeTrans,
    smallTrans,
    tinyTrans
  } walkState_t;

endpackage

`default_nettype wire

/* hdl/mmuTop.sv */
`timescale 1ns/1ps
`default_nettype none

`include "mmu_config.svh"

module mmuTop
  import mmuPkg::*;
(
  input  logic                       clk,
  input  logic                       reset,
  input  logic                       cpuRequest,
  input  logic                       cpuWrite,
  input  virtAddr_t                  virtAddr,
  input  logic                       supMode,
  input  logic                       wordAccess,
  output logic                       cpuReady,
  output physAddr_t                  hAddr,
  output logic                       hRequest,
  output logic                       hWrite,
  input  logic                       hReady,
  input  descriptor_t                hRData,
  input  logic [`MMU_ADDR_WIDTH-1:0] control,
  input  tableBase_t                 tableBase,
  input  logic [31:0]                domainAccess,
  input  logic                       extAbort,
  output logic                       dataAbort,
  output logic                       cp15WriteEn,
  output cp15Reg_t                   cp15Addr,
  output logic [31:0]                cp15WriteData
);

  logic        enable;
  logic        sBit;
  logic        rBit;
  walkState_t  state;
  logic        descCapture;
  logic        walkRequest;
  logic        walkWrite;
  logic        walkReady;
  logic        walkFault;
  descriptor_t desc;
  domain_t     domain;
  physAddr_t   walkAddr;
  logic        fault;
  faultCode_t  faultCode;
  logic        reportBusy;

  assign enable = control[`MMU_CTRL_ENABLE];
  assign sBit   = control[`MMU_CTRL_SBIT];
  assign rBit   = control[`MMU_CTRL_RBIT];

  // MMU off means a flat mapping straight to the bus
  assign hAddr     = enable ? walkAddr : virtAddr;
  assign hRequest  = enable ? walkRequest : cpuRequest;
  assign hWrite    = enable ? walkWrite : cpuWrite;
  assign cpuReady  = enable ? walkReady : hReady;
  assign dataAbort = enable && walkFault;

  walkControl i_walkControl (
    .clk         (clk),
    .reset       (reset),
    .enable      (enable),
    .cpuRequest  (cpuRequest),
    .cpuWrite    (cpuWrite),
    .hReady      (hReady),
    .hRData      (hRData),
    .fault       (fault),
    .reportBusy  (reportBusy),
    .state       (state),
    .descCapture (descCapture),
    .walkRequest (walkRequest),
    .walkWrite   (walkWrite),
    .walkReady   (walkReady),
    .walkFault   (walkFault)
  );

  descriptorPath i_descriptorPath (
    .clk         (clk),
    .reset       (reset),
    .state       (state),
    .descCapture (descCapture),
    .hRData      (hRData),
    .virtAddr    (virtAddr),
    .tableBase   (tableBase),
    .desc        (desc),
    .domain      (domain),
    .walkAddr    (walkAddr)
  );

  permissionCheck i_permissionCheck (
    .state        (state),
    .desc         (desc),
    .hRData       (hRData),
    .domain       (domain),
    .domainAccess (domainAccess),
    .virtAddr     (virtAddr),
    .cpuRequest   (cpuRequest),
    .cpuWrite     (cpuWrite),
    .supMode      (supMode),
    .wordAccess   (wordAccess),
    .sBit         (sBit),
    .rBit         (rBit),
    .extAbort     (extAbort),
    .hReady       (hReady),
    .fault        (fault),
    .faultCode    (faultCode)
  );

  faultReporter i_faultReporter (
    .clk           (clk),
    .reset         (reset),
    .dataAbort     (dataAbort),
    .faultCode     (faultCode),
    .domain        (domain),
    .virtAddr      (virtAddr),
    .cp15WriteEn   (cp15WriteEn),
    .cp15Addr      (cp15Addr),
    .cp15WriteData (cp15WriteData),
    .reportBusy    (reportBusy)
  );

endmodule

`default_nettype wire

/* hdl/mmu_config.svh */
`ifndef MMU_CONFIG_SVH
`define MMU_CONFIG_SVH

// Bus and address widths
`define MMU_ADDR_WIDTH  32
`define MMU_TBASE_WIDTH 18

// CP15 fault registers
`define MMU_CP15_FSR 5
`define MMU_CP15_FAR 6

// Control word bits
`define MMU_CTRL_ENABLE 0
`define MMU_CTRL_SBIT   7  // System protection
`define MMU_CTRL_RBIT   9  // ROM protection

`endif

/* hdl/permissionCheck.sv */
`timescale 1ns/1ps
`default_nettype none

module permissionCheck
  import mmuPkg::*;
(
  input  walkState_t  state,
  input  descriptor_t desc,
  input  descriptor_t hRData,
  input  domain_t     domain,
  input  logic [31:0] domainAccess,
  input  virtAddr_t   virtAddr,
  input  logic        cpuRequest,
  input  logic        cpuWrite,
  input  logic        supMode,
  input  logic        wordAccess,
  input  logic        sBit,
  input  logic        rBit,
  input  logic        extAbort,
  input  logic        hReady,
  output logic        fault,
  output faultCode_t  faultCode
);

  logic [1:0]  domainEntry;
  accessPerm_t accessPerm;
  logic        domainFault;
  logic        apFault;
  logic        permFault;
  logic        fetchDone;

  // Subpage AP pairs sit at [5:4], [7:6], [9:8] and [11:10]
  function automatic accessPerm_t subPageAp(input descriptor_t word, input logic [1:0] sel);
    return word[4 + 2 * sel +: 2];
  endfunction

  assign domainEntry = domainAccess[{domain, 1'b0} +: 2];
  assign domainFault = !domainEntry[0];  // 00 no access, 10 reserved
  assign fetchDone   = cpuRequest && hReady;

  always_comb begin
    case (state)
      sectionTrans: accessPerm = desc[11:10];
      largeTrans:   accessPerm = subPageAp(desc, virtAddr[15:14]);
      smallTrans:   accessPerm = subPageAp(desc, virtAddr[11:10]);
      tinyTrans:    accessPerm = desc[5:4];
      default:      accessPerm = 2'b11;
    endcase
  end

  always_comb begin
    case (accessPerm)
      2'b11: apFault = 1'b0;
      2'b10: apFault = !supMode && cpuWrite;  // User read only
      2'b01: apFault = !supMode;              // Supervisor only
      default: begin
        case ({sBit, rBit})
          2'b10:   apFault = !(supMode && !cpuWrite);
          2'b01:   apFault = cpuWrite;
          default: apFault = 1'b1;
        endcase
      end
    endcase
  end

  // Managers bypass AP entirely
  assign permFault = (domainEntry == 2'b01) && apFault;

  always_comb begin
    fault     = 1'b0;
    faultCode = alignFault;
    case (state)
      ready: begin
        if (cpuRequest && wordAccess && (virtAddr[1:0] != 2'b00)) fault = 1'b1;
      end
      firstFetch: begin
        if (fetchDone && extAbort) begin
          fault     = 1'b1;
          faultCode = firstExtFault;
        end else if (fetchDone && (hRData[1:0] == 2'b00)) begin
          fault     = 1'b1;
          faultCode = sectionTransFault;
        end
      end
      coarseFetch, fineFetch: begin
        if (fetchDone && extAbort) begin
          fault     = 1'b1;
          faultCode = secondExtFault;
        end else if (fetchDone && ((hRData[1:0] == 2'b00) ||
                     ((state == coarseFetch) && (hRData[1:0] == 2'b11)))) begin
          fault     = 1'b1;
          faultCode = pageTransFault;  // Tiny pages only exist in fine tables
        end
      end
      sectionTrans: begin
        if (cpuRequest && domainFault) begin
          fault     = 1'b1;
          faultCode = sectionDomainFault;
        end else if (cpuRequest && permFault) begin
          fault     = 1'b1;
          faultCode = sectionPermFault;
        end
      end
      default: begin
        if (cpuRequest && domainFault) begin
          fault     = 1'b1;
          faultCode = pageDomainFault;
        end else if (cpuRequest && permFault) begin
          fault     = 1'b1;
          faultCode = pagePermFault;
        end
      end
    endcase
  end

endmodule

`default_nettype wire

/* hdl/walkControl.sv */
`timescale 1ns/1ps
`default_nettype none

module walkControl
  import mmuPkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        enable,
  input  logic        cpuRequest,
  input  logic        cpuWrite,
  input  logic        hReady,
  input  descriptor_t hRData,
  input  logic        fault,
  input  logic        reportBusy,
  output walkState_t  state,
  output logic        descCapture,
  output logic        walkRequest,
  output logic        walkWrite,
  output logic        walkReady,
  output logic        walkFault
);

  walkState_t nextState;
  logic       fetchState;
  logic       transState;
  logic       dropWalk;

  assign fetchState = state inside {firstFetch, coarseFetch, fineFetch};
  assign transState = state inside {sectionTrans, largeTrans, smallTrans, tinyTrans};
  assign dropWalk   = !cpuRequest || !enable;

  // An alignment fault waits in ready until the CP15 writes of the last abort finish
  assign walkFault   = fault && !((state == ready) && reportBusy);
  assign descCapture = fetchState && cpuRequest && hReady;

  // Fetches keep the request up; a faulting translation never reaches the bus
  assign walkRequest = cpuRequest && (fetchState || (transState && !fault));
  assign walkWrite   = transState && cpuWrite;  // Descriptor fetches are reads
  assign walkReady   = transState && walkRequest && hReady;

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (enable && cpuRequest && !reportBusy && !fault) nextState = firstFetch;
      end
      firstFetch: begin
        if (dropWalk || fault) begin
          nextState = ready;
        end else if (hReady) begin
          case (hRData[1:0])
            2'b01:   nextState = coarseFetch;
            2'b11:   nextState = fineFetch;
            default: nextState = sectionTrans;
          endcase
        end
      end
      coarseFetch: begin
        if (dropWalk || fault) begin
          nextState = ready;
        end else if (hReady) begin
          nextState = hRData[0] ? largeTrans : smallTrans;  // Tiny and 00 already faulted
        end
      end
      fineFetch: begin
        if (dropWalk || fault) begin
          nextState = ready;
        end else if (hReady) begin
          case (hRData[1:0])
            2'b01:   nextState = largeTrans;
            2'b11:   nextState = tinyTrans;
            default: nextState = smallTrans;
          endcase
        end
      end
      default: begin
        // Translated access ends on completion, abort or a dropped request
        if (dropWalk || fault || hReady) nextState = ready;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= ready;
    end else begin
      state <= nextState;
    end
  end

  // A walk ends either with the CPU handshake or with an abort, never both
  assert property (@(posedge clk) disable iff (reset) !(walkReady && walkFault))
    else $error("walkControl: cpuReady and data abort in the same cycle");

endmodule

`default_nettype wire

/* mmuWalk.f */
+incdir+hdl
hdl/mmuPkg.sv
hdl/walkControl.sv
hdl/descriptorPath.sv
hdl/permissionCheck.sv
hdl/faultReporter.sv
hdl/mmuTop.sv
bench/mmuTb.sv
